// File: hdl/mul_defs.svh
/*
 * Width and depth macros for the multiply unit
 * Word width, partial product slicing, pipeline latency
 */

`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

// --------------------
// Datapath widths
`define MUL_XLEN        32  // Register width
`define MUL_SLICE_W     8   // Multiplier slice per partial product
`define MUL_NUM_SLICES  4   // MUL_XLEN / MUL_SLICE_W

// --------------------
// Timing
`define MUL_LATENCY     3   // Request edge to response, edges

`endif

// File: hdl/mul_op_pkg.sv
/*
 * M-extension multiply operation codes
 * Operand signedness lookup per operation
 */

package mul_op_pkg;

  // Same order as funct3[1:0] of the multiply group
  typedef enum logic [1:0] {
    MUL_OP_MUL    = 2'b00,  // Low word, sign does not matter
    MUL_OP_MULH   = 2'b01,  // Signed x signed, high word
    MUL_OP_MULHSU = 2'b10,  // Signed x unsigned, high word
    MUL_OP_MULHU  = 2'b11   // Unsigned x unsigned, high word
  } mul_op_e;

  // True when the chosen operand is signed for this op
  function automatic logic operand_signed(input mul_op_e op, input logic is_rs2);
    logic sgn;
    case (op)
      MUL_OP_MULH:   sgn = 1'b1;     // Both signed
      MUL_OP_MULHSU: sgn = !is_rs2;  // Only rs1 signed
      default:       sgn = 1'b0;     // MUL treated unsigned, low word identical
    endcase
    return sgn;
  endfunction

endpackage

// File: hdl/mul_data_pkg.sv
/*
 * Datapath types of the multiply unit
 * Word, product and partial product vectors
 * Request, response and pipeline tag structs
 */

`include "mul_defs.svh"

package mul_data_pkg;

  // Plain vectors with a meaning
  typedef logic [`MUL_XLEN-1:0]              xlen_t;   // One register word
  typedef logic [2*`MUL_XLEN-1:0]            dword_t;  // Full 64-bit product
  typedef logic [`MUL_XLEN+`MUL_SLICE_W-1:0] pprod_t;  // 8x32 partial product

  // Request from the execute stage
  typedef struct packed {
    logic                 valid;  // Take a request this cycle
    mul_op_pkg::mul_op_e  op;     // MUL / MULH / MULHSU / MULHU
    xlen_t                rs1;
    xlen_t                rs2;
  } mul_req_t;

  // Travels next to each item in the core
  typedef struct packed {
    logic negate;  // Result sign is negative
    logic high;    // Return upper word
  } mul_tag_t;

  // Result back to the core
  typedef struct packed {
    logic  valid;   // One-cycle pulse per result
    xlen_t result;
  } mul_rsp_t;

endpackage

// File: hdl/mul_operand_prep.sv
/*
 * Operand preparation for the multiply unit
 * Signed operands turned into magnitudes
 * Result sign and half selection packed into the pipeline tag
 */

`include "mul_defs.svh"

module mul_operand_prep (
  input  mul_data_pkg::mul_req_t req_i,    // Request from execute
  output logic                   start_o,  // Item enters the core
  output mul_data_pkg::xlen_t    a_o,      // Multiplicand magnitude
  output mul_data_pkg::xlen_t    b_o,      // Multiplier magnitude
  output mul_data_pkg::mul_tag_t tag_o     // Sign and half of the result
);

  import mul_op_pkg::*;
  import mul_data_pkg::*;

  // --------------------
  // Effective operand signs
  logic  rs1_signed;  // rs1 is interpreted as signed
  logic  rs2_signed;
  logic  rs1_neg;     // Signed and MSB set
  logic  rs2_neg;

  xlen_t rs1_mag;
  xlen_t rs2_mag;

  always_comb begin
    rs1_signed = operand_signed(req_i.op, 1'b0);
    rs2_signed = operand_signed(req_i.op, 1'b1);

    rs1_neg = rs1_signed & req_i.rs1[`MUL_XLEN-1];
    rs2_neg = rs2_signed & req_i.rs2[`MUL_XLEN-1];
  end

  // --------------------
  // Magnitudes

  // Two's complement negate; 32'h8000_0000 stays put, which is 2^31 unsigned
  always_comb begin
    rs1_mag = req_i.rs1;
    if (rs1_neg) begin
      rs1_mag = xlen_t'(~req_i.rs1 + xlen_t'(1));
    end
  end

  always_comb begin
    rs2_mag = req_i.rs2;
    if (rs2_neg) begin
      rs2_mag = xlen_t'(~req_i.rs2 + xlen_t'(1));
    end
  end

  // --------------------
  // Core interface
  assign start_o = req_i.valid;
  assign a_o     = rs1_mag;
  assign b_o     = rs2_mag;

  // Product is negative when exactly one operand is
  always_comb begin
    tag_o        = '0;
    tag_o.negate = rs1_neg ^ rs2_neg;
    tag_o.high   = (req_i.op != MUL_OP_MUL);  // Every op but MUL wants the top word
  end

endmodule

// File: hdl/mul_pipelined.sv
/*
 * Two-stage unsigned 32x32 multiplier core
 * Stage 1 forms four 8x32 partial products
 * Stage 2 sums them with byte shifts
 * Output register holds the product and a done pulse
 * A tag and a valid bit ride along with each item
 */

`include "mul_defs.svh"

module mul_pipelined (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   start_i,    // New item this cycle
  input  mul_data_pkg::xlen_t    a_i,        // Multiplicand
  input  mul_data_pkg::xlen_t    b_i,        // Multiplier sliced by bytes
  input  mul_data_pkg::mul_tag_t tag_i,
  output mul_data_pkg::dword_t   product_o,  // Full unsigned product
  output mul_data_pkg::mul_tag_t tag_o,      // Tag of the item on product_o
  output logic                   done_o,     // One pulse per item
  output logic                   busy_o      // Any stage occupied
);

  import mul_data_pkg::*;

  // Stage 1 state
  pprod_t [`MUL_NUM_SLICES-1:0] pp_d;
  pprod_t [`MUL_NUM_SLICES-1:0] pp_q;   // Partial products with slice 0 lowest
  mul_tag_t                     s1_tag_q;
  logic                         s1_vld_q;

  // Stage 2 state
  dword_t                       sum_d;
  dword_t                       sum_q;
  mul_tag_t                     s2_tag_q;
  logic                         s2_vld_q;

  // --------------------
  // Stage 1 partial products

  // Each slice is a_i times one byte of b_i in 40 bits
  always_comb begin
    for (int i = 0; i < `MUL_NUM_SLICES; i++) begin
      pp_d[i] = pprod_t'(a_i) * pprod_t'(b_i[i*`MUL_SLICE_W +: `MUL_SLICE_W]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pp_q     <= '0;
      s1_tag_q <= '0;
      s1_vld_q <= 1'b0;
    end else begin
      s1_vld_q <= start_i;
      if (start_i) begin  // Hold data when idle
        pp_q     <= pp_d;
        s1_tag_q <= tag_i;
      end
    end
  end

  // --------------------
  // Stage 2 shifted sum
  always_comb begin
    sum_d = '0;
    for (int i = 0; i < `MUL_NUM_SLICES; i++) begin
      sum_d = sum_d + (dword_t'(pp_q[i]) << (i * `MUL_SLICE_W));  // Top carries drop off
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sum_q    <= '0;
      s2_tag_q <= '0;
      s2_vld_q <= 1'b0;
    end else begin
      s2_vld_q <= s1_vld_q;
      if (s1_vld_q) begin
        sum_q    <= sum_d;
        s2_tag_q <= s1_tag_q;
      end
    end
  end

  // --------------------
  // Output register
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      product_o <= '0;
      tag_o     <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= s2_vld_q;  // Single pulse that follows the item
      if (s2_vld_q) begin
        product_o <= sum_q;
        tag_o     <= s2_tag_q;
      end
    end
  end

  assign busy_o = s1_vld_q | s2_vld_q | done_o;

  // --------------------
  // Checks

  // Start sampled at one edge shows as done at the third edge after it
  a_done_after_start : assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> ##(`MUL_LATENCY) done_o)
    else $error("done_o missing three edges after start_i");

  a_done_has_start : assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> $past(start_i, `MUL_LATENCY))
    else $error("done_o without a matching start_i");

  a_product_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> !$isunknown(product_o))
    else $error("product_o unknown while done_o is high");

endmodule

// File: hdl/mul_result_sel.sv
/*
 * Result stage of the multiply unit
 * Sign restore of the 64-bit product
 * High or low word select, response forming
 */

`include "mul_defs.svh"

module mul_result_sel (
  input  logic                   done_i,     // Core has an item
  input  mul_data_pkg::dword_t   product_i,  // Unsigned magnitude product
  input  mul_data_pkg::mul_tag_t tag_i,      // Sign and half of this item
  output mul_data_pkg::mul_rsp_t rsp_o
);

  import mul_data_pkg::*;

  dword_t prod_signed;  // Product with sign restored
  xlen_t  prod_hi;
  xlen_t  prod_lo;
  xlen_t  word_sel;

  // --------------------
  // Sign restore

  // Full 64-bit negate so the borrow reaches the upper word
  always_comb begin
    prod_signed = product_i;
    if (tag_i.negate) begin
      prod_signed = dword_t'(~product_i + dword_t'(1));
    end
  end

  // --------------------
  // Word select
  assign prod_hi = prod_signed[2*`MUL_XLEN-1:`MUL_XLEN];
  assign prod_lo = prod_signed[`MUL_XLEN-1:0];

  always_comb begin
    if (tag_i.high) begin
      word_sel = prod_hi;  // MULH, MULHSU, MULHU
    end else begin
      word_sel = prod_lo;  // MUL
    end
  end

  // --------------------
  // Response

  // Zero when empty so the last result does not linger on the bus
  always_comb begin
    rsp_o       = '0;
    rsp_o.valid = done_i;
    if (done_i) begin
      rsp_o.result = word_sel;
    end
  end

endmodule

// File: hdl/mul_unit_top.sv
/*
 * Multiply unit of the M extension
 * Operand prep, two-stage core, result select
 */

module mul_unit_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  mul_data_pkg::mul_req_t req_i,   // One request per cycle, no ready
  output mul_data_pkg::mul_rsp_t rsp_o,   // Result three edges later
  output logic                   busy_o   // Items in flight
);

  import mul_data_pkg::*;

  // --------------------
  // Prep to core
  logic     start;
  xlen_t    mag_a;
  xlen_t    mag_b;
  mul_tag_t tag_in;

  // Core to result select
  dword_t   product;
  mul_tag_t tag_out;
  logic     done;

  // --------------------
  // Operand magnitudes and result sign
  mul_operand_prep u_prep (
    .req_i   (req_i),
    .start_o (start),
    .a_o     (mag_a),
    .b_o     (mag_b),
    .tag_o   (tag_in)
  );

  // Unsigned product, two stages plus output register
  mul_pipelined u_core (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (start),
    .a_i       (mag_a),
    .b_i       (mag_b),
    .tag_i     (tag_in),
    .product_o (product),
    .tag_o     (tag_out),
    .done_o    (done),
    .busy_o    (busy_o)
  );

  // Sign restore and word pick
  mul_result_sel u_sel (
    .done_i    (done),
    .product_i (product),
    .tag_i     (tag_out),
    .rsp_o     (rsp_o)
  );

endmodule

// File: tests/tb_mul_unit.sv
/*
 * Testbench for the multiply unit
 * Fixed corner table plus seeded random entries, reference model
 * Response monitor with latency and order checks, busy and reset checks
 */

`include "mul_defs.svh"

module tb_mul_unit;

  timeunit 1ns;
  timeprecision 1ps;

  import mul_data_pkg::*;
  import mul_op_pkg::*;

  localparam int unsigned SEED         = 32'h711a20d6;
  localparam int unsigned RESET_CYCLES = 8;
  localparam int unsigned NUM_RANDOM   = 200;
  localparam int unsigned DRAIN_LIMIT  = 20;   // Cycles to empty the pipeline
  localparam int unsigned NUM_GAPPED   = 4;    // Table entries reissued with idle gaps

  // One table row with its expected word
  typedef struct packed {
    mul_op_e op;
    xlen_t   rs1;
    xlen_t   rs2;
    xlen_t   exp;
  } test_vec_t;

  // Outstanding response
  typedef struct packed {
    xlen_t       result;
    int unsigned due;     // Edge count at which it must show
  } exp_rsp_t;

  logic     clk_i = 1'b0;
  logic     rst_ni;
  mul_req_t req_i;
  mul_rsp_t rsp_o;
  logic     busy_o;

  test_vec_t   vec_q[$];    // Stimulus table
  exp_rsp_t    exp_q[$];    // Expected responses in request order
  int unsigned cyc = 0;     // Rising edges seen so far
  int unsigned n_issued = 0;
  int unsigned n_checked = 0;

  mul_unit_top dut_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (req_i),
    .rsp_o  (rsp_o),
    .busy_o (busy_o)
  );

  always #20 clk_i = ~clk_i;  // 40 ns period

  always @(posedge clk_i) cyc <= cyc + 1;

  // --------------------
  // Failure reporting
  task automatic stop_with_failure();
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // --------------------
  // Reference model with sign or zero extension and a full 64-bit product
  function automatic xlen_t ref_result(input mul_op_e op, input xlen_t rs1, input xlen_t rs2);
    dword_t a_ext;
    dword_t b_ext;
    dword_t prod;
    logic   a_sext;
    logic   b_sext;
    a_sext = (op == MUL_OP_MULH) || (op == MUL_OP_MULHSU);
    b_sext = (op == MUL_OP_MULH);                        // MULHSU keeps rs2 unsigned
    a_ext  = a_sext ? {{`MUL_XLEN{rs1[`MUL_XLEN-1]}}, rs1} : {{`MUL_XLEN{1'b0}}, rs1};
    b_ext  = b_sext ? {{`MUL_XLEN{rs2[`MUL_XLEN-1]}}, rs2} : {{`MUL_XLEN{1'b0}}, rs2};
    prod   = a_ext * b_ext;                              // Low 64 bits exact for both signs
    if (op == MUL_OP_MUL) begin
      return prod[`MUL_XLEN-1:0];
    end
    return prod[2*`MUL_XLEN-1:`MUL_XLEN];
  endfunction

  // Fixed row with a hand-worked result that the model must agree with
  task automatic add_vec(input mul_op_e op, input xlen_t rs1, input xlen_t rs2, input xlen_t exp);
    if (ref_result(op, rs1, rs2) !== exp) begin
      $display("ERROR: reference model disagrees with table row %0d", vec_q.size());
      stop_with_failure();
    end
    vec_q.push_back('{op: op, rs1: rs1, rs2: rs2, exp: exp});
  endtask

  // --------------------
  // Drivers
  task automatic issue_req(input test_vec_t v);
    mul_req_t r;
    r.valid = 1'b1;
    r.op    = v.op;
    r.rs1   = v.rs1;
    r.rs2   = v.rs2;
    @(posedge clk_i);
    req_i <= r;
    exp_q.push_back('{result: v.exp, due: cyc + 1 + `MUL_LATENCY});  // cyc not yet bumped
    n_issued++;
  endtask

  task automatic idle_req();
    @(posedge clk_i);
    req_i <= '0;
  endtask

  // Polls on rising edges while the monitor pops on falling ones
  task automatic wait_idle(input int unsigned max_cycles);
    int unsigned n;
    n = 0;
    while ((busy_o || exp_q.size() != 0) && n < max_cycles) begin
      @(posedge clk_i);
      n++;
    end
    if (busy_o || exp_q.size() != 0) begin
      $display("ERROR: pipeline still busy or responses missing after %0d cycles", max_cycles);
      stop_with_failure();
    end
  endtask

  // --------------------
  // Response monitor sampled mid-cycle
  always @(negedge clk_i) begin
    exp_rsp_t e;
    if (!rst_ni) begin
      check_bit("rsp_o.valid in reset", rsp_o.valid, 1'b0);
      check_bit("busy_o in reset", busy_o, 1'b0);
    end
    if (rsp_o.valid) begin
      if (exp_q.size() == 0) begin
        $display("ERROR: response at edge %0d with no request outstanding", cyc);
        stop_with_failure();
      end
      e = exp_q.pop_front();
      if (cyc != e.due) begin
        $display("ERROR: response at edge %0d, expected at edge %0d", cyc, e.due);
        stop_with_failure();
      end
      check_word("rsp_o.result", rsp_o.result, e.result);
      n_checked++;
    end else begin
      check_word("rsp_o.result idle", rsp_o.result, '0);  // No stale word between pulses
    end
  end

  // --------------------
  // Main sequence
  initial begin
    xlen_t     r1;
    xlen_t     r2;
    xlen_t     r3;
    test_vec_t v;

    rst_ni = 1'b0;
    req_i  = '0;
    void'($urandom(SEED));

    // Low word with mixed sign and zero operands
    add_vec(MUL_OP_MUL,    32'h0000_0007, 32'hFFFF_FFFD, 32'hFFFF_FFEB);
    add_vec(MUL_OP_MUL,    32'h0000_0000, 32'h1234_5678, 32'h0000_0000);
    add_vec(MUL_OP_MUL,    32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001);
    add_vec(MUL_OP_MUL,    32'h0001_0000, 32'h0001_0000, 32'h0000_0000);
    add_vec(MUL_OP_MUL,    32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
    // High word corners
    add_vec(MUL_OP_MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
    add_vec(MUL_OP_MULH,   32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
    add_vec(MUL_OP_MULH,   32'h0000_0002, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    add_vec(MUL_OP_MULH,   32'h7FFF_FFFF, 32'h7FFF_FFFF, 32'h3FFF_FFFF);
    add_vec(MUL_OP_MULH,   32'h8000_0000, 32'h0000_0001, 32'hFFFF_FFFF);
    add_vec(MUL_OP_MULHU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE);
    add_vec(MUL_OP_MULHU,  32'h8000_0000, 32'h0000_0002, 32'h0000_0001);
    add_vec(MUL_OP_MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    add_vec(MUL_OP_MULHSU, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
    add_vec(MUL_OP_MULHSU, 32'h0000_0003, 32'h8000_0000, 32'h0000_0001);

    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    idle_req();
    @(negedge clk_i);
    check_bit("rsp_o.valid after reset", rsp_o.valid, 1'b0);
    check_bit("busy_o after reset", busy_o, 1'b0);

    // Fixed table back to back
    foreach (vec_q[i]) issue_req(vec_q[i]);
    idle_req();
    wait_idle(DRAIN_LIMIT);

    // Isolated requests with busy checked in flight and after
    for (int i = 0; i < NUM_GAPPED; i++) begin
      issue_req(vec_q[i]);
      idle_req();
      for (int k = 0; k < `MUL_LATENCY; k++) begin
        @(negedge clk_i);
        check_bit("busy_o in flight", busy_o, 1'b1);  // Stage 1, stage 2, output register
      end
      @(negedge clk_i);
      check_bit("busy_o when empty", busy_o, 1'b0);
      wait_idle(DRAIN_LIMIT);
    end

    // Random entries over all four ops
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r1    = $urandom();
      r2    = $urandom();
      r3    = $urandom();
      v.op  = mul_op_e'(r3[1:0]);
      v.rs1 = r1;
      v.rs2 = r2;
      v.exp = ref_result(v.op, r1, r2);
      issue_req(v);
    end
    idle_req();
    wait_idle(DRAIN_LIMIT);

    if (n_checked == n_issued) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("ERROR: %0d requests issued but %0d responses checked", n_issued, n_checked);
      stop_with_failure();
    end
  end

endmodule

// File: src.f
+incdir+hdl
hdl/mul_op_pkg.sv
hdl/mul_data_pkg.sv
hdl/mul_operand_prep.sv
hdl/mul_pipelined.sv
hdl/mul_result_sel.sv
hdl/mul_unit_top.sv
tests/tb_mul_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the multiply unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f src.f \
  --top-module tb_mul_unit \
  -o sim_mul_unit

out=$(./obj_dir/sim_mul_unit)
echo "$out"

if echo "$out" | grep -q "TESTS PASSED"; then
  exit 0
fi
exit 1
